//--- mps_reg_pkg.sv
package mps_reg_pkg;

	// AXI4-Lite bus geometry
	localparam int AXI_DATA_W = 32;
	localparam int AXI_ADDR_W = 5;
	localparam int ADDR_LSB   = 2;
	localparam int WORD_W     = AXI_ADDR_W - ADDR_LSB;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	// Word addresses
	localparam logic [WORD_W-1:0] REG_CTRL       = 3'd0;
	localparam logic [WORD_W-1:0] REG_EXT_DO     = 3'd1;
	localparam logic [WORD_W-1:0] REG_INTL_MASK  = 3'd2;
	localparam logic [WORD_W-1:0] REG_INTL_CLR   = 3'd3;
	localparam logic [WORD_W-1:0] REG_STATUS     = 3'd4;
	localparam logic [WORD_W-1:0] REG_EXT_DI     = 3'd5;
	localparam logic [WORD_W-1:0] REG_INTL_LATCH = 3'd6;

	// Command bits in CTRL and INTL_CLR
	localparam int CTRL_ON_BIT   = 0;
	localparam int CTRL_OFF_BIT  = 1;
	localparam int INTL_CLR_BIT  = 0;

	// STATUS word layout, state sits in the low bits
	localparam int STAT_PWM_BIT  = 4;
	localparam int STAT_CONT_BIT = 5;
	localparam int STAT_INTL_BIT = 8;

	// External digital I/O widths
	localparam int EXT_DO_W = 5;
	localparam int EXT_DI_W = 16;

endpackage

//--- mps_ctrl_pkg.sv
package mps_ctrl_pkg;

	// Sequencer states
	typedef enum logic [2:0] {
		ST_IDLE       = 3'd0,
		ST_PRECHARGE  = 3'd1,
		ST_READY      = 3'd2,
		ST_RUN        = 3'd3,
		ST_RAMP_DOWN  = 3'd4,
		ST_FAULT      = 3'd5
	} mps_state_e;

	// Step lengths in clock cycles
	localparam int PRECHARGE_CYCLES = 16;
	localparam int RAMP_CYCLES      = 8;

	// Step counter must hold the longer of the two
	localparam int STEP_MAX = (PRECHARGE_CYCLES > RAMP_CYCLES) ?
		PRECHARGE_CYCLES : RAMP_CYCLES;
	localparam int STEP_W   = $clog2(STEP_MAX + 1);

	// Analog interlock channels
	localparam int INTL_W = 17;

endpackage

//--- mps_axi_regs.sv
`timescale 1ns/1ps

module mps_axi_regs
(
	input  logic                                   S_AXI_ACLK,
	input  logic                                   S_AXI_ARESETN,

	input  logic [mps_reg_pkg::AXI_ADDR_W-1:0]     S_AXI_AWADDR,
	input  logic [2:0]                             S_AXI_AWPROT,
	input  logic                                   S_AXI_AWVALID,
	output logic                                   S_AXI_AWREADY,
	input  logic [mps_reg_pkg::AXI_DATA_W-1:0]     S_AXI_WDATA,
	input  logic [mps_reg_pkg::AXI_DATA_W/8-1:0]   S_AXI_WSTRB,
	input  logic                                   S_AXI_WVALID,
	output logic                                   S_AXI_WREADY,
	output logic [1:0]                             S_AXI_BRESP,
	output logic                                   S_AXI_BVALID,
	input  logic                                   S_AXI_BREADY,
	input  logic [mps_reg_pkg::AXI_ADDR_W-1:0]     S_AXI_ARADDR,
	input  logic [2:0]                             S_AXI_ARPROT,
	input  logic                                   S_AXI_ARVALID,
	output logic                                   S_AXI_ARREADY,
	output logic [mps_reg_pkg::AXI_DATA_W-1:0]     S_AXI_RDATA,
	output logic [1:0]                             S_AXI_RRESP,
	output logic                                   S_AXI_RVALID,
	input  logic                                   S_AXI_RREADY,

	input  mps_ctrl_pkg::mps_state_e               i_state,
	input  logic                                   i_pwm_en,
	input  logic                                   i_contactor,
	input  logic                                   i_intl_active,
	input  logic [mps_ctrl_pkg::INTL_W-1:0]        i_intl_latch,
	input  logic [mps_reg_pkg::EXT_DI_W-1:0]       i_ext_di,

	output logic                                   o_cmd_on,
	output logic                                   o_cmd_off,
	output logic                                   o_intl_clr,
	output logic [mps_ctrl_pkg::INTL_W-1:0]        o_intl_mask,
	output logic [mps_reg_pkg::EXT_DO_W-1:0]       o_ext_do
);

	import mps_reg_pkg::*;
	import mps_ctrl_pkg::*;

	logic                  awready_r;
	logic                  wready_r;
	logic                  bvalid_r;
	logic                  arready_r;
	logic                  rvalid_r;
	logic [AXI_DATA_W-1:0] rdata_r;

	logic                  wr_fire;
	logic                  rd_fire;
	logic [WORD_W-1:0]     wr_word;
	logic [WORD_W-1:0]     rd_word;
	logic [AXI_DATA_W-1:0] wr_merged;
	logic [AXI_DATA_W-1:0] rd_mux;
	logic [AXI_DATA_W-1:0] status_word;

	// Sampled read-only words
	logic [AXI_DATA_W-1:0] status_r;
	logic [EXT_DI_W-1:0]   ext_di_r;
	logic [INTL_W-1:0]     latch_r;

	// Byte lanes with a set strobe take the new data
	function automatic logic [AXI_DATA_W-1:0] merge_strb(
		input logic [AXI_DATA_W-1:0]   old_val,
		input logic [AXI_DATA_W-1:0]   new_val,
		input logic [AXI_DATA_W/8-1:0] strb
	);
		logic [AXI_DATA_W-1:0] res;
		res = old_val;
		for (int b = 0; b < AXI_DATA_W / 8; b++)
		begin
			if (strb[b])
				res[8*b +: 8] = new_val[8*b +: 8];
		end
		return res;
	endfunction

	assign wr_fire = awready_r && S_AXI_AWVALID && wready_r && S_AXI_WVALID;
	assign rd_fire = arready_r && S_AXI_ARVALID;
	assign wr_word = S_AXI_AWADDR[AXI_ADDR_W-1:ADDR_LSB];
	assign rd_word = S_AXI_ARADDR[AXI_ADDR_W-1:ADDR_LSB];

	// Address and data accepted together, never over a pending response
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			awready_r <= 1'b0;
			wready_r  <= 1'b0;
		end
		else
		begin
			awready_r <= !awready_r && S_AXI_AWVALID && S_AXI_WVALID && !bvalid_r;
			wready_r  <= !wready_r && S_AXI_AWVALID && S_AXI_WVALID && !bvalid_r;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			bvalid_r <= 1'b0;
		else if (wr_fire)
			bvalid_r <= 1'b1;
		else if (S_AXI_BREADY)
			bvalid_r <= 1'b0;
	end

	// Only one register is written per transfer, so one merge serves all
	always_comb
	begin
		wr_merged = '0;
		case (wr_word)
			REG_EXT_DO:
				wr_merged = merge_strb(AXI_DATA_W'(o_ext_do), S_AXI_WDATA, S_AXI_WSTRB);
			REG_INTL_MASK:
				wr_merged = merge_strb(AXI_DATA_W'(o_intl_mask), S_AXI_WDATA, S_AXI_WSTRB);
			default:
				wr_merged = '0;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_ext_do    <= '0;
			o_intl_mask <= '1;
		end
		else if (wr_fire)
		begin
			if (wr_word == REG_EXT_DO)
				o_ext_do <= wr_merged[EXT_DO_W-1:0];
			if (wr_word == REG_INTL_MASK)
				o_intl_mask <= wr_merged[INTL_W-1:0];
		end
	end

	// CTRL and INTL_CLR are not stored, they fire one-cycle pulses
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_cmd_on   <= 1'b0;
			o_cmd_off  <= 1'b0;
			o_intl_clr <= 1'b0;
		end
		else
		begin
			o_cmd_on   <= wr_fire && (wr_word == REG_CTRL) && S_AXI_WSTRB[0]
				&& S_AXI_WDATA[CTRL_ON_BIT];
			o_cmd_off  <= wr_fire && (wr_word == REG_CTRL) && S_AXI_WSTRB[0]
				&& S_AXI_WDATA[CTRL_OFF_BIT];
			o_intl_clr <= wr_fire && (wr_word == REG_INTL_CLR) && S_AXI_WSTRB[0]
				&& S_AXI_WDATA[INTL_CLR_BIT];
		end
	end

	always_comb
	begin
		status_word = '0;
		status_word[$bits(mps_state_e)-1:0] = i_state;
		status_word[STAT_PWM_BIT]  = i_pwm_en;
		status_word[STAT_CONT_BIT] = i_contactor;
		status_word[STAT_INTL_BIT] = i_intl_active;
	end

	// Status inputs sampled every cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		status_r <= status_word;
		ext_di_r <= i_ext_di;
		latch_r  <= i_intl_latch;
	end

	// ARREADY held off while a read response is still pending
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			arready_r <= 1'b0;
		else
			arready_r <= !arready_r && S_AXI_ARVALID && !rvalid_r;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rvalid_r <= 1'b0;
		else if (rd_fire)
			rvalid_r <= 1'b1;
		else if (S_AXI_RREADY)
			rvalid_r <= 1'b0;
	end

	always_comb
	begin
		case (rd_word)
			REG_EXT_DO:     rd_mux = AXI_DATA_W'(o_ext_do);
			REG_INTL_MASK:  rd_mux = AXI_DATA_W'(o_intl_mask);
			REG_STATUS:     rd_mux = status_r;
			REG_EXT_DI:     rd_mux = AXI_DATA_W'(ext_di_r);
			REG_INTL_LATCH: rd_mux = AXI_DATA_W'(latch_r);
			// CTRL, INTL_CLR and unmapped words read as zero
			default:        rd_mux = '0;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (rd_fire)
			rdata_r <= rd_mux;
	end

	assign S_AXI_AWREADY = awready_r;
	assign S_AXI_WREADY  = wready_r;
	assign S_AXI_BRESP   = RESP_OKAY;
	assign S_AXI_BVALID  = bvalid_r;
	assign S_AXI_ARREADY = arready_r;
	assign S_AXI_RDATA   = rdata_r;
	assign S_AXI_RRESP   = RESP_OKAY;
	assign S_AXI_RVALID  = rvalid_r;

endmodule

//--- mps_sequencer.sv
`timescale 1ns/1ps

module mps_sequencer
(
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	input  logic                      i_cmd_on,
	input  logic                      i_cmd_off,
	input  logic                      i_intl_active,
	output mps_ctrl_pkg::mps_state_e  o_state,
	output logic                      o_pwm_en,
	output logic                      o_contactor
);

	import mps_ctrl_pkg::*;

	mps_state_e        state_nxt;
	logic [STEP_W-1:0] step_cnt;
	logic              precharge_done;
	logic              ramp_done;

	assign precharge_done = (step_cnt == STEP_W'(PRECHARGE_CYCLES - 1));
	assign ramp_done      = (step_cnt == STEP_W'(RAMP_CYCLES - 1));

	always_comb
	begin
		state_nxt = o_state;
		// Interlock overrides every state
		if (i_intl_active)
			state_nxt = ST_FAULT;
		else
		begin
			case (o_state)
				ST_IDLE:
				begin
					if (i_cmd_on)
						state_nxt = ST_PRECHARGE;
				end
				ST_PRECHARGE:
				begin
					if (i_cmd_off)
						state_nxt = ST_RAMP_DOWN;
					else if (precharge_done)
						state_nxt = ST_READY;
				end
				ST_READY:
				begin
					// Off wins if both arrive together
					if (i_cmd_off)
						state_nxt = ST_RAMP_DOWN;
					else if (i_cmd_on)
						state_nxt = ST_RUN;
				end
				ST_RUN:
				begin
					if (i_cmd_off)
						state_nxt = ST_RAMP_DOWN;
				end
				ST_RAMP_DOWN:
				begin
					if (ramp_done)
						state_nxt = ST_IDLE;
				end
				ST_FAULT:
					state_nxt = ST_IDLE;
				default:
					state_nxt = ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_state     <= ST_IDLE;
			step_cnt    <= '0;
			o_pwm_en    <= 1'b0;
			o_contactor <= 1'b0;
		end
		else
		begin
			o_state <= state_nxt;
			// Step count restarts on every state change
			if (state_nxt != o_state)
				step_cnt <= '0;
			else
				step_cnt <= step_cnt + 1'b1;
			o_pwm_en    <= (state_nxt == ST_RUN);
			o_contactor <= (state_nxt == ST_PRECHARGE) || (state_nxt == ST_READY)
				|| (state_nxt == ST_RUN) || (state_nxt == ST_RAMP_DOWN);
		end
	end

endmodule

//--- mps_interlock.sv
`timescale 1ns/1ps

module mps_interlock
(
	input  logic                             S_AXI_ACLK,
	input  logic                             S_AXI_ARESETN,
	input  logic [mps_ctrl_pkg::INTL_W-1:0]  i_analog_intl,
	input  logic [mps_ctrl_pkg::INTL_W-1:0]  i_mask,
	input  logic                             i_clr,
	output logic [mps_ctrl_pkg::INTL_W-1:0]  o_latch,
	output logic                             o_active
);

	import mps_ctrl_pkg::*;

	logic [INTL_W-1:0] masked;

	// Mask bit high means the channel is enabled
	assign masked = i_analog_intl & i_mask;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_latch <= '0;
		else if (i_clr)
			o_latch <= '0;
		else
			o_latch <= o_latch | masked;
	end

	// A fault still present after a clear sets the bit again next edge
	assign o_active = |o_latch;

endmodule

//--- mps_top.sv
`timescale 1ns/1ps

module mps_top
(
	input  logic                                   S_AXI_ACLK,
	input  logic                                   S_AXI_ARESETN,
	input  logic [mps_reg_pkg::AXI_ADDR_W-1:0]     S_AXI_AWADDR,
	input  logic [2:0]                             S_AXI_AWPROT,
	input  logic                                   S_AXI_AWVALID,
	output logic                                   S_AXI_AWREADY,
	input  logic [mps_reg_pkg::AXI_DATA_W-1:0]     S_AXI_WDATA,
	input  logic [mps_reg_pkg::AXI_DATA_W/8-1:0]   S_AXI_WSTRB,
	input  logic                                   S_AXI_WVALID,
	output logic                                   S_AXI_WREADY,
	output logic [1:0]                             S_AXI_BRESP,
	output logic                                   S_AXI_BVALID,
	input  logic                                   S_AXI_BREADY,
	input  logic [mps_reg_pkg::AXI_ADDR_W-1:0]     S_AXI_ARADDR,
	input  logic [2:0]                             S_AXI_ARPROT,
	input  logic                                   S_AXI_ARVALID,
	output logic                                   S_AXI_ARREADY,
	output logic [mps_reg_pkg::AXI_DATA_W-1:0]     S_AXI_RDATA,
	output logic [1:0]                             S_AXI_RRESP,
	output logic                                   S_AXI_RVALID,
	input  logic                                   S_AXI_RREADY,

	input  logic [mps_ctrl_pkg::INTL_W-1:0]        i_analog_intl,
	input  logic [mps_reg_pkg::EXT_DI_W-1:0]       i_ext_di,
	output logic [mps_reg_pkg::EXT_DO_W-1:0]       o_ext_do,
	output logic                                   o_pwm_en,
	output logic                                   o_contactor
);

	import mps_ctrl_pkg::*;

	logic              cmd_on;
	logic              cmd_off;
	logic              intl_clr;
	logic [INTL_W-1:0] intl_mask;
	logic [INTL_W-1:0] intl_latch;
	logic              intl_active;
	mps_state_e        state;

	mps_axi_regs u_regs
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_AWADDR  (S_AXI_AWADDR),
		.S_AXI_AWPROT  (S_AXI_AWPROT),
		.S_AXI_AWVALID (S_AXI_AWVALID),
		.S_AXI_AWREADY (S_AXI_AWREADY),
		.S_AXI_WDATA   (S_AXI_WDATA),
		.S_AXI_WSTRB   (S_AXI_WSTRB),
		.S_AXI_WVALID  (S_AXI_WVALID),
		.S_AXI_WREADY  (S_AXI_WREADY),
		.S_AXI_BRESP   (S_AXI_BRESP),
		.S_AXI_BVALID  (S_AXI_BVALID),
		.S_AXI_BREADY  (S_AXI_BREADY),
		.S_AXI_ARADDR  (S_AXI_ARADDR),
		.S_AXI_ARPROT  (S_AXI_ARPROT),
		.S_AXI_ARVALID (S_AXI_ARVALID),
		.S_AXI_ARREADY (S_AXI_ARREADY),
		.S_AXI_RDATA   (S_AXI_RDATA),
		.S_AXI_RRESP   (S_AXI_RRESP),
		.S_AXI_RVALID  (S_AXI_RVALID),
		.S_AXI_RREADY  (S_AXI_RREADY),
		.i_state       (state),
		.i_pwm_en      (o_pwm_en),
		.i_contactor   (o_contactor),
		.i_intl_active (intl_active),
		.i_intl_latch  (intl_latch),
		.i_ext_di      (i_ext_di),
		.o_cmd_on      (cmd_on),
		.o_cmd_off     (cmd_off),
		.o_intl_clr    (intl_clr),
		.o_intl_mask   (intl_mask),
		.o_ext_do      (o_ext_do)
	);

	mps_sequencer u_seq
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_cmd_on      (cmd_on),
		.i_cmd_off     (cmd_off),
		.i_intl_active (intl_active),
		.o_state       (state),
		.o_pwm_en      (o_pwm_en),
		.o_contactor   (o_contactor)
	);

	mps_interlock u_intl
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_analog_intl (i_analog_intl),
		.i_mask        (intl_mask),
		.i_clr         (intl_clr),
		.o_latch       (intl_latch),
		.o_active      (intl_active)
	);

endmodule

//--- mps_top_sva.sv
`timescale 1ns/1ps

module mps_top_sva
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic i_awvalid,
	input logic i_awready,
	input logic i_bvalid,
	input logic i_bready,
	input logic i_rvalid,
	input logic i_rready,
	input logic i_pwm_en,
	input logic i_contactor
);

	// Responses stay up until the host takes them
	a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_bvalid && !i_bready |=> i_bvalid)
		else $error("BVALID dropped before BREADY");

	a_rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_rvalid && !i_rready |=> i_rvalid)
		else $error("RVALID dropped before RREADY");

	// PWM only with the contactor closed
	a_pwm_needs_contactor: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_pwm_en |-> i_contactor)
		else $error("PWM enabled while contactor open");

	a_no_write_over_bvalid: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_awready && i_awvalid |-> !i_bvalid)
		else $error("Write accepted while a write response was pending");

endmodule

bind mps_top mps_top_sva u_sva
(
	.S_AXI_ACLK    (S_AXI_ACLK),
	.S_AXI_ARESETN (S_AXI_ARESETN),
	.i_awvalid     (S_AXI_AWVALID),
	.i_awready     (S_AXI_AWREADY),
	.i_bvalid      (S_AXI_BVALID),
	.i_bready      (S_AXI_BREADY),
	.i_rvalid      (S_AXI_RVALID),
	.i_rready      (S_AXI_RREADY),
	.i_pwm_en      (o_pwm_en),
	.i_contactor   (o_contactor)
);

//--- tb_mps_top.sv
`timescale 1ns/1ps

module tb_mps_top;

	import mps_reg_pkg::*;
	import mps_ctrl_pkg::*;

	localparam int WAIT_LIMIT  = 64;
	localparam int HOLD_CYCLES = 4;

	localparam logic [AXI_ADDR_W-1:0] EXT_DO_ADDR = AXI_ADDR_W'(REG_EXT_DO) << ADDR_LSB;
	localparam logic [AXI_ADDR_W-1:0] EXT_DI_ADDR = AXI_ADDR_W'(REG_EXT_DI) << ADDR_LSB;

	logic                    S_AXI_ACLK;
	logic                    S_AXI_ARESETN;
	logic [AXI_ADDR_W-1:0]   axi_awaddr;
	logic                    axi_awvalid;
	logic                    axi_awready;
	logic [AXI_DATA_W-1:0]   axi_wdata;
	logic [AXI_DATA_W/8-1:0] axi_wstrb;
	logic                    axi_wvalid;
	logic                    axi_wready;
	logic [1:0]              axi_bresp;
	logic                    axi_bvalid;
	logic                    axi_bready;
	logic [AXI_ADDR_W-1:0]   axi_araddr;
	logic                    axi_arvalid;
	logic                    axi_arready;
	logic [AXI_DATA_W-1:0]   axi_rdata;
	logic [1:0]              axi_rresp;
	logic                    axi_rvalid;
	logic                    axi_rready;
	logic [INTL_W-1:0]       analog_intl;
	logic [EXT_DI_W-1:0]     ext_di;
	logic [EXT_DO_W-1:0]     ext_do;
	logic                    pwm_en;
	logic                    contactor;

	int mismatch_count;
	int other_errors;

	mps_top i_dut
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_AWADDR  (axi_awaddr),
		.S_AXI_AWPROT  (3'b000),
		.S_AXI_AWVALID (axi_awvalid),
		.S_AXI_AWREADY (axi_awready),
		.S_AXI_WDATA   (axi_wdata),
		.S_AXI_WSTRB   (axi_wstrb),
		.S_AXI_WVALID  (axi_wvalid),
		.S_AXI_WREADY  (axi_wready),
		.S_AXI_BRESP   (axi_bresp),
		.S_AXI_BVALID  (axi_bvalid),
		.S_AXI_BREADY  (axi_bready),
		.S_AXI_ARADDR  (axi_araddr),
		.S_AXI_ARPROT  (3'b000),
		.S_AXI_ARVALID (axi_arvalid),
		.S_AXI_ARREADY (axi_arready),
		.S_AXI_RDATA   (axi_rdata),
		.S_AXI_RRESP   (axi_rresp),
		.S_AXI_RVALID  (axi_rvalid),
		.S_AXI_RREADY  (axi_rready),
		.i_analog_intl (analog_intl),
		.i_ext_di      (ext_di),
		.o_ext_do      (ext_do),
		.o_pwm_en      (pwm_en),
		.o_contactor   (contactor)
	);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever
			#4 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
			mismatch_count++;
		end
	endtask

	// Called on a falling edge, returns on a falling edge
	task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int waited;
		axi_awaddr  = addr;
		axi_wdata   = data;
		axi_wstrb   = strb;
		axi_awvalid = 1'b1;
		axi_wvalid  = 1'b1;
		waited = 0;
		@(negedge S_AXI_ACLK);
		while (!(axi_awready && axi_wready) && waited < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			waited++;
		end
		if (!(axi_awready && axi_wready))
		begin
			$display("Write to address %h was never accepted", addr);
			other_errors++;
		end
		@(negedge S_AXI_ACLK);
		axi_awvalid = 1'b0;
		axi_wvalid  = 1'b0;
		waited = 0;
		while (!axi_bvalid && waited < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			waited++;
		end
		if (!axi_bvalid)
		begin
			$display("No write response for address %h", addr);
			other_errors++;
		end
		else
		begin
			check_value(32'(axi_bresp), 32'(RESP_OKAY), "write response");
			axi_bready = 1'b1;
			@(negedge S_AXI_ACLK);
			axi_bready = 1'b0;
		end
	endtask

	task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data);
		int waited;
		data = '0;
		axi_araddr  = addr;
		axi_arvalid = 1'b1;
		waited = 0;
		@(negedge S_AXI_ACLK);
		while (!axi_arready && waited < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			waited++;
		end
		if (!axi_arready)
		begin
			$display("Read of address %h was never accepted", addr);
			other_errors++;
		end
		@(negedge S_AXI_ACLK);
		axi_arvalid = 1'b0;
		waited = 0;
		while (!axi_rvalid && waited < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			waited++;
		end
		if (!axi_rvalid)
		begin
			$display("No read data for address %h", addr);
			other_errors++;
		end
		else
		begin
			check_value(32'(axi_rresp), 32'(RESP_OKAY), "read response");
			data = axi_rdata;
			axi_rready = 1'b1;
			@(negedge S_AXI_ACLK);
			axi_rready = 1'b0;
		end
	endtask

	// A second write offered while BVALID is held must wait for BREADY
	task automatic write_under_backpressure(input logic [EXT_DO_W-1:0] first_val,
		input logic [EXT_DO_W-1:0] second_val);
		int waited;
		axi_awaddr  = EXT_DO_ADDR;
		axi_wdata   = 32'(first_val);
		axi_wstrb   = 4'hf;
		axi_awvalid = 1'b1;
		axi_wvalid  = 1'b1;
		waited = 0;
		@(negedge S_AXI_ACLK);
		while (!(axi_awready && axi_wready) && waited < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			waited++;
		end
		if (!(axi_awready && axi_wready))
		begin
			$display("First write of the back-pressure test was never accepted");
			other_errors++;
			axi_awvalid = 1'b0;
			axi_wvalid  = 1'b0;
			return;
		end
		@(negedge S_AXI_ACLK);
		// Second write stays offered, BREADY stays low
		axi_wdata = 32'(second_val);
		repeat (HOLD_CYCLES)
		begin
			check_value(32'(axi_bvalid), 32'd1, "BVALID held without BREADY");
			check_value(32'(axi_awready || axi_wready), 32'd0, "write ready while BVALID held");
			check_value(32'(ext_do), 32'(first_val), "ext_do while second write blocked");
			@(negedge S_AXI_ACLK);
		end
		axi_bready = 1'b1;
		@(negedge S_AXI_ACLK);
		axi_bready = 1'b0;
		waited = 0;
		while (!(axi_awready && axi_wready) && waited < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			waited++;
		end
		if (!(axi_awready && axi_wready))
		begin
			$display("Blocked write was not accepted after the response was taken");
			other_errors++;
		end
		@(negedge S_AXI_ACLK);
		axi_awvalid = 1'b0;
		axi_wvalid  = 1'b0;
		waited = 0;
		while (!axi_bvalid && waited < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			waited++;
		end
		if (!axi_bvalid)
		begin
			$display("No write response for the blocked write");
			other_errors++;
		end
		else
		begin
			axi_bready = 1'b1;
			@(negedge S_AXI_ACLK);
			axi_bready = 1'b0;
		end
		check_value(32'(ext_do), 32'(second_val), "ext_do after blocked write");
	endtask

	// A second read offered while RVALID is held must wait for RREADY
	task automatic read_under_backpressure(input logic [AXI_ADDR_W-1:0] first_addr,
		input logic [31:0] first_exp, input logic [AXI_ADDR_W-1:0] second_addr,
		input logic [31:0] second_exp);
		int waited;
		axi_araddr  = first_addr;
		axi_arvalid = 1'b1;
		waited = 0;
		@(negedge S_AXI_ACLK);
		while (!axi_arready && waited < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			waited++;
		end
		if (!axi_arready)
		begin
			$display("First read of the back-pressure test was never accepted");
			other_errors++;
			axi_arvalid = 1'b0;
			return;
		end
		@(negedge S_AXI_ACLK);
		axi_araddr = second_addr;
		repeat (HOLD_CYCLES)
		begin
			check_value(32'(axi_rvalid), 32'd1, "RVALID held without RREADY");
			check_value(32'(axi_arready), 32'd0, "ARREADY while RVALID held");
			check_value(axi_rdata, first_exp, "read data while RVALID held");
			@(negedge S_AXI_ACLK);
		end
		axi_rready = 1'b1;
		@(negedge S_AXI_ACLK);
		axi_rready = 1'b0;
		waited = 0;
		while (!axi_arready && waited < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			waited++;
		end
		if (!axi_arready)
		begin
			$display("Blocked read was not accepted after the data was taken");
			other_errors++;
		end
		@(negedge S_AXI_ACLK);
		axi_arvalid = 1'b0;
		waited = 0;
		while (!axi_rvalid && waited < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			waited++;
		end
		if (!axi_rvalid)
		begin
			$display("No read data for the blocked read");
			other_errors++;
		end
		else
		begin
			check_value(axi_rdata, second_exp, "read data of blocked read");
			axi_rready = 1'b1;
			@(negedge S_AXI_ACLK);
			axi_rready = 1'b0;
		end
	endtask

	task automatic poll_read(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] expected,
		input int limit);
		logic [31:0] data;
		int          tries;
		bit          matched;
		matched = 0;
		tries = 0;
		while (!matched && tries < limit)
		begin
			axi_read(addr, data);
			matched = (data === expected);
			tries++;
		end
		if (!matched)
		begin
			$display("Address %h did not reach %h within %0d reads, last value %h",
				addr, expected, limit, data);
			other_errors++;
		end
	endtask

	// One command per line, fields in hex
	task automatic play_script();
		int                 fd;
		int                 n;
		logic [63:0]        cmd;
		logic [31:0]        a;
		logic [31:0]        b;
		logic [31:0]        c;
		logic [31:0]        rd;
		logic [8*128-1:0]   rest_of_line;
		fd = $fopen("mps_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the test data file mps_testdata.txt");
			other_errors++;
			return;
		end
		n = $fscanf(fd, "%s", cmd);
		while (n == 1)
		begin
			if (cmd == "#")
				n = $fgets(rest_of_line, fd);
			else
			begin
				n = $fscanf(fd, "%h %h %h", a, b, c);
				if (n != 3)
				begin
					$display("Test data line for command %s has missing fields", cmd);
					other_errors++;
				end
				else
				begin
					case (cmd)
						"W": axi_write(a[AXI_ADDR_W-1:0], b, c[3:0]);
						"R":
						begin
							axi_read(a[AXI_ADDR_W-1:0], rd);
							check_value(rd, b, $sformatf("read of address %h", a));
						end
						"P": poll_read(a[AXI_ADDR_W-1:0], b, int'(c));
						"A": analog_intl = a[INTL_W-1:0];
						"D": ext_di = a[EXT_DI_W-1:0];
						"O": check_value(32'({ext_do, pwm_en, contactor}), a,
							"ext_do, pwm_en and contactor");
						default:
						begin
							$display("Unknown command %s in test data", cmd);
							other_errors++;
						end
					endcase
				end
			end
			n = $fscanf(fd, "%s", cmd);
		end
		$fclose(fd);
	endtask

	initial
	begin
		S_AXI_ARESETN = 1'b0;
		axi_awaddr    = '0;
		axi_awvalid   = 1'b0;
		axi_wdata     = '0;
		axi_wstrb     = '0;
		axi_wvalid    = 1'b0;
		axi_bready    = 1'b0;
		axi_araddr    = '0;
		axi_arvalid   = 1'b0;
		axi_rready    = 1'b0;
		analog_intl   = '0;
		ext_di        = '0;
		mismatch_count = 0;
		other_errors   = 0;
		repeat (8) @(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		@(negedge S_AXI_ACLK);
		play_script();
		ext_di = 16'h3c5a;
		write_under_backpressure(5'h0a, 5'h1f);
		read_under_backpressure(EXT_DO_ADDR, 32'h1f, EXT_DI_ADDR, 32'h3c5a);
		$display("Mismatches: %0d, other errors: %0d", mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- mps_testdata.txt
# cmd a b c, all fields hex, unused fields 0
# W addr data strb | R addr expect | P addr expect tries | A analog | D ext_di | O {do,pwm,cont}
O 0 0 0
R 08 1ffff 0
W 04 ffffffd5 f
R 04 15 0
O 54 0 0
W 08 0 f
R 08 0 0
W 08 0001ff00 4
R 08 10000 0
W 08 12345678 1
R 08 10078 0
W 1c ffffffff f
R 1c 0 0
R 00 0 0
D a5c3 0 0
R 14 a5c3 0
W 08 f f
W 00 1 f
P 10 21 4
P 10 22 20
O 55 0 0
W 00 1 f
P 10 33 4
O 57 0 0
W 00 2 f
P 10 24 4
P 10 0 8
O 54 0 0
W 00 1 f
P 10 22 20
W 00 1 f
P 10 33 4
A 10000 0 0
R 10 33 0
R 18 0 0
A 10004 0 0
P 10 105 4
P 18 4 4
O 54 0 0
W 0c 1 f
P 18 4 4
P 10 105 8
A 10000 0 0
W 0c 1 f
P 10 0 8
R 18 0 0
O 54 0 0
A 0 0 0

//--- verilog.f
mps_reg_pkg.sv
mps_ctrl_pkg.sv
mps_axi_regs.sv
mps_sequencer.sv
mps_interlock.sv
mps_top.sv
mps_top_sva.sv
tb_mps_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MPS testbench with Verilator, the log decides the result
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mps_top -f verilog.f \
	&& ./obj_dir/Vtb_mps_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^ALL TESTS PASSED$" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
